//--- design/gat_mem_macros.svh
// GAT memory widths and depths

`ifndef GAT_MEM_MACROS_SVH
`define GAT_MEM_MACROS_SVH

// Weight and feature word
`define GAT_DATA_WIDTH      8

// Sparse H data word holding a value and its column index
`define GAT_COL_IDX_WIDTH   4
`define GAT_H_DATA_WIDTH    (`GAT_DATA_WIDTH + `GAT_COL_IDX_WIDTH)
`define GAT_H_DATA_DEPTH    64
`define GAT_H_DATA_ADDR_W   ($clog2(`GAT_H_DATA_DEPTH))

// Weights
`define GAT_WGT_DEPTH       64
`define GAT_WGT_ADDR_W      ($clog2(`GAT_WGT_DEPTH))

// WH result rows
`define GAT_WH_WIDTH        24
`define GAT_WH_DEPTH        32
`define GAT_WH_ADDR_W       ($clog2(`GAT_WH_DEPTH))

// New features written back by the layers
`define GAT_FEAT_WIDTH      16
`define GAT_FEAT_DEPTH      32
`define GAT_FEAT_ADDR_W     ($clog2(`GAT_FEAT_DEPTH))

// Host register bus
`define GAT_CFG_WIDTH       8

`endif

//--- design/gat_mem_pkg.sv
// GAT memory shared types

`default_nettype none

package gat_mem_pkg;

  // Layer that owns the shared memories
  typedef enum logic [0:0] {
    CONV1 = 1'b0,
    CONV2 = 1'b1
  } gat_layer_e;

  // Host register map
  typedef enum logic [1:0] {
    CFG_LAYER  = 2'd0,
    CFG_STATUS = 2'd1,
    CFG_CLEAR  = 2'd2
  } cfg_addr_e;

endpackage

`default_nettype wire

//--- design/gat_bram_if.sv
// Layer engine result memory port

`default_nettype none

`include "gat_mem_macros.svh"

interface gat_bram_if #(
  parameter int DATA_W = `GAT_WH_WIDTH,
  parameter int ADDR_W = `GAT_WH_ADDR_W
) ();

  logic [DATA_W-1:0] din;
  logic              ena;
  logic [ADDR_W-1:0] addra;
  logic [ADDR_W-1:0] addrb;

  // Layer engine side
  modport engine (output din, ena, addra, addrb);

  // Memory controller side
  modport ctrl (input din, ena, addra, addrb);

endinterface

`default_nettype wire

//--- design/bram.sv
// Single read port block memory

`default_nettype none

`include "gat_mem_macros.svh"

module bram #(
  parameter int DATA_WIDTH = `GAT_DATA_WIDTH,
  parameter int DEPTH      = `GAT_WGT_DEPTH,
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ena,
  input  logic                  wea,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic [ADDR_W-1:0]     addra,
  input  logic [ADDR_W-1:0]     addrb,
  output logic [DATA_WIDTH-1:0] dout
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (ena && wea) begin
      mem[addra] <= din;
    end
  end

  // Registered read returns old data on a colliding write
  always_ff @(posedge clk) begin
    if (reset) begin
      dout <= '0;
    end else begin
      dout <= mem[addrb];
    end
  end

endmodule

`default_nettype wire

//--- design/dual_read_bram.sv
// Block memory with two read ports

`default_nettype none

`include "gat_mem_macros.svh"

module dual_read_bram #(
  parameter int DATA_WIDTH = `GAT_WH_WIDTH,
  parameter int DEPTH      = `GAT_WH_DEPTH,
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ena,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic [ADDR_W-1:0]     addra,
  input  logic [ADDR_W-1:0]     addrb,
  input  logic [ADDR_W-1:0]     addrc,
  output logic [DATA_WIDTH-1:0] doutb,
  output logic [DATA_WIDTH-1:0] doutc
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Write port from the active layer
  always_ff @(posedge clk) begin
    if (ena) begin
      mem[addra] <= din;
    end
  end

  // Port b serves the layer engine, port c the host
  always_ff @(posedge clk) begin
    if (reset) begin
      doutb <= '0;
      doutc <= '0;
    end else begin
      doutb <= mem[addrb];
      doutc <= mem[addrc];
    end
  end

endmodule

`default_nettype wire

//--- design/gat_mem_regs.sv
// Host configuration registers

`default_nettype none

`include "gat_mem_macros.svh"

module gat_mem_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          cfg_we,
  input  gat_mem_pkg::cfg_addr_e        cfg_addr,
  input  logic [`GAT_CFG_WIDTH-1:0]     cfg_wdata,
  output logic [`GAT_CFG_WIDTH-1:0]     cfg_rdata,
  input  logic                          h_data_load_done,
  input  logic                          wgt_load_done,
  output gat_mem_pkg::gat_layer_e       gat_layer
);

  logic h_data_done;
  logic wgt_done;
  logic clear_status;

  assign clear_status = cfg_we && (cfg_addr == gat_mem_pkg::CFG_CLEAR);

  // Layer select
  always_ff @(posedge clk) begin
    if (reset) begin
      gat_layer <= gat_mem_pkg::CONV1;
    end else if (cfg_we && (cfg_addr == gat_mem_pkg::CFG_LAYER)) begin
      gat_layer <= gat_mem_pkg::gat_layer_e'(cfg_wdata[0]);
    end
  end

  // Sticky load-done bits where a pulse beats a clear
  always_ff @(posedge clk) begin
    if (reset) begin
      h_data_done <= 1'b0;
      wgt_done    <= 1'b0;
    end else begin
      if (h_data_load_done) begin
        h_data_done <= 1'b1;
      end else if (clear_status) begin
        h_data_done <= 1'b0;
      end
      if (wgt_load_done) begin
        wgt_done <= 1'b1;
      end else if (clear_status) begin
        wgt_done <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      gat_mem_pkg::CFG_LAYER: begin
        cfg_rdata[0] = gat_layer;
      end
      gat_mem_pkg::CFG_STATUS: begin
        cfg_rdata[2:0] = {h_data_done && wgt_done, wgt_done, h_data_done};
      end
      default: begin
        cfg_rdata = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/memory_controller.sv
// Per-layer memory steering

`default_nettype none

`include "gat_mem_macros.svh"

module memory_controller (
  input  logic                            clk,
  input  logic                            reset,
  input  gat_mem_pkg::gat_layer_e         gat_layer,

  // ========================================================================
  // Host load ports
  // ========================================================================
  input  logic [`GAT_H_DATA_WIDTH-1:0]    h_data_din,
  input  logic                            h_data_ena,
  input  logic                            h_data_wea,
  input  logic [`GAT_H_DATA_ADDR_W-1:0]   h_data_addra,
  input  logic [`GAT_DATA_WIDTH-1:0]      wgt_din,
  input  logic                            wgt_ena,
  input  logic                            wgt_wea,
  input  logic [`GAT_WGT_ADDR_W-1:0]      wgt_addra,

  // ========================================================================
  // Layer read ports
  // ========================================================================
  input  logic [`GAT_H_DATA_ADDR_W-1:0]   h_data_addrb_conv1,
  input  logic [`GAT_H_DATA_ADDR_W-1:0]   h_data_addrb_conv2,
  input  logic [`GAT_WGT_ADDR_W-1:0]      wgt_addrb_conv1,
  input  logic [`GAT_WGT_ADDR_W-1:0]      wgt_addrb_conv2,
  output logic [`GAT_H_DATA_WIDTH-1:0]    h_data_dout,
  output logic [`GAT_DATA_WIDTH-1:0]      wgt_dout,

  // Result memories
  gat_bram_if.ctrl                        wh_conv1,
  gat_bram_if.ctrl                        wh_conv2,
  gat_bram_if.ctrl                        feat_conv1,
  gat_bram_if.ctrl                        feat_conv2,
  input  logic [`GAT_WH_ADDR_W-1:0]       wh_addrc,
  output logic [`GAT_WH_WIDTH-1:0]        wh_dout,
  output logic [`GAT_WH_WIDTH-1:0]        wh_doutc,
  output logic [`GAT_FEAT_WIDTH-1:0]      feat_dout
);

  logic [`GAT_H_DATA_ADDR_W-1:0] h_data_addrb;
  logic [`GAT_WGT_ADDR_W-1:0]    wgt_addrb;
  logic [`GAT_WH_WIDTH-1:0]      wh_din;
  logic                          wh_ena;
  logic [`GAT_WH_ADDR_W-1:0]     wh_addra;
  logic [`GAT_WH_ADDR_W-1:0]     wh_addrb;
  logic [`GAT_FEAT_WIDTH-1:0]    feat_din;
  logic                          feat_ena;
  logic [`GAT_FEAT_ADDR_W-1:0]   feat_addra;
  logic [`GAT_FEAT_ADDR_W-1:0]   feat_addrb;

  // Only the selected layer reaches the memories
  always_comb begin
    if (gat_layer == gat_mem_pkg::CONV1) begin
      h_data_addrb = h_data_addrb_conv1;
      wgt_addrb    = wgt_addrb_conv1;
      wh_din       = wh_conv1.din;
      wh_ena       = wh_conv1.ena;
      wh_addra     = wh_conv1.addra;
      wh_addrb     = wh_conv1.addrb;
      feat_din     = feat_conv1.din;
      feat_ena     = feat_conv1.ena;
      feat_addra   = feat_conv1.addra;
      feat_addrb   = feat_conv1.addrb;
    end else begin
      h_data_addrb = h_data_addrb_conv2;
      wgt_addrb    = wgt_addrb_conv2;
      wh_din       = wh_conv2.din;
      wh_ena       = wh_conv2.ena;
      wh_addra     = wh_conv2.addra;
      wh_addrb     = wh_conv2.addrb;
      feat_din     = feat_conv2.din;
      feat_ena     = feat_conv2.ena;
      feat_addra   = feat_conv2.addra;
      feat_addrb   = feat_conv2.addrb;
    end
  end

  // ========================================================================
  // Memory instances
  // ========================================================================
  bram #(
    .DATA_WIDTH (`GAT_H_DATA_WIDTH),
    .DEPTH      (`GAT_H_DATA_DEPTH)
  ) u_h_data_bram (
    .clk   (clk),
    .reset (reset),
    .ena   (h_data_ena),
    .wea   (h_data_wea),
    .din   (h_data_din),
    .addra (h_data_addra),
    .addrb (h_data_addrb),
    .dout  (h_data_dout)
  );

  bram #(
    .DATA_WIDTH (`GAT_DATA_WIDTH),
    .DEPTH      (`GAT_WGT_DEPTH)
  ) u_wgt_bram (
    .clk   (clk),
    .reset (reset),
    .ena   (wgt_ena),
    .wea   (wgt_wea),
    .din   (wgt_din),
    .addra (wgt_addra),
    .addrb (wgt_addrb),
    .dout  (wgt_dout)
  );

  // Host reads WH results on port c
  dual_read_bram #(
    .DATA_WIDTH (`GAT_WH_WIDTH),
    .DEPTH      (`GAT_WH_DEPTH)
  ) u_wh_bram (
    .clk   (clk),
    .reset (reset),
    .ena   (wh_ena),
    .din   (wh_din),
    .addra (wh_addra),
    .addrb (wh_addrb),
    .addrc (wh_addrc),
    .doutb (wh_dout),
    .doutc (wh_doutc)
  );

  // Layer strobe acts as both enable and write enable
  bram #(
    .DATA_WIDTH (`GAT_FEAT_WIDTH),
    .DEPTH      (`GAT_FEAT_DEPTH)
  ) u_feat_bram (
    .clk   (clk),
    .reset (reset),
    .ena   (feat_ena),
    .wea   (feat_ena),
    .din   (feat_din),
    .addra (feat_addra),
    .addrb (feat_addrb),
    .dout  (feat_dout)
  );

endmodule

`default_nettype wire

//--- design/gat_mem_top.sv
// GAT memory subsystem top level

`default_nettype none

`include "gat_mem_macros.svh"

module gat_mem_top (
  input  logic                            clk,
  input  logic                            reset,

  // ========================================================================
  // Host side
  // ========================================================================
  input  logic [`GAT_H_DATA_WIDTH-1:0]    h_data_din,
  input  logic                            h_data_ena,
  input  logic                            h_data_wea,
  input  logic [`GAT_H_DATA_ADDR_W-1:0]   h_data_addra,
  input  logic                            h_data_load_done,
  input  logic [`GAT_DATA_WIDTH-1:0]      wgt_din,
  input  logic                            wgt_ena,
  input  logic                            wgt_wea,
  input  logic [`GAT_WGT_ADDR_W-1:0]      wgt_addra,
  input  logic                            wgt_load_done,
  input  logic [`GAT_WH_ADDR_W-1:0]       wh_addrc,
  output logic [`GAT_WH_WIDTH-1:0]        wh_doutc,
  input  logic                            cfg_we,
  input  logic [1:0]                      cfg_addr,
  input  logic [`GAT_CFG_WIDTH-1:0]       cfg_wdata,
  output logic [`GAT_CFG_WIDTH-1:0]       cfg_rdata,

  // ========================================================================
  // Layer engines
  // ========================================================================
  input  logic [`GAT_H_DATA_ADDR_W-1:0]   h_data_addrb_conv1,
  input  logic [`GAT_H_DATA_ADDR_W-1:0]   h_data_addrb_conv2,
  input  logic [`GAT_WGT_ADDR_W-1:0]      wgt_addrb_conv1,
  input  logic [`GAT_WGT_ADDR_W-1:0]      wgt_addrb_conv2,
  output logic [`GAT_H_DATA_WIDTH-1:0]    h_data_dout,
  output logic [`GAT_DATA_WIDTH-1:0]      wgt_dout,
  input  logic [`GAT_WH_WIDTH-1:0]        wh_din_conv1,
  input  logic                            wh_ena_conv1,
  input  logic [`GAT_WH_ADDR_W-1:0]       wh_addra_conv1,
  input  logic [`GAT_WH_ADDR_W-1:0]       wh_addrb_conv1,
  input  logic [`GAT_WH_WIDTH-1:0]        wh_din_conv2,
  input  logic                            wh_ena_conv2,
  input  logic [`GAT_WH_ADDR_W-1:0]       wh_addra_conv2,
  input  logic [`GAT_WH_ADDR_W-1:0]       wh_addrb_conv2,
  output logic [`GAT_WH_WIDTH-1:0]        wh_dout,
  input  logic [`GAT_FEAT_WIDTH-1:0]      feat_din_conv1,
  input  logic                            feat_ena_conv1,
  input  logic [`GAT_FEAT_ADDR_W-1:0]     feat_addra_conv1,
  input  logic [`GAT_FEAT_ADDR_W-1:0]     feat_addrb_conv1,
  input  logic [`GAT_FEAT_WIDTH-1:0]      feat_din_conv2,
  input  logic                            feat_ena_conv2,
  input  logic [`GAT_FEAT_ADDR_W-1:0]     feat_addra_conv2,
  input  logic [`GAT_FEAT_ADDR_W-1:0]     feat_addrb_conv2,
  output logic [`GAT_FEAT_WIDTH-1:0]      feat_dout
);

  gat_mem_pkg::gat_layer_e gat_layer;

  gat_bram_if #(.DATA_W(`GAT_WH_WIDTH), .ADDR_W(`GAT_WH_ADDR_W)) wh_conv1 ();
  gat_bram_if #(.DATA_W(`GAT_WH_WIDTH), .ADDR_W(`GAT_WH_ADDR_W)) wh_conv2 ();
  gat_bram_if #(.DATA_W(`GAT_FEAT_WIDTH), .ADDR_W(`GAT_FEAT_ADDR_W)) feat_conv1 ();
  gat_bram_if #(.DATA_W(`GAT_FEAT_WIDTH), .ADDR_W(`GAT_FEAT_ADDR_W)) feat_conv2 ();

  // Bundle each layer's result ports
  assign wh_conv1.din     = wh_din_conv1;
  assign wh_conv1.ena     = wh_ena_conv1;
  assign wh_conv1.addra   = wh_addra_conv1;
  assign wh_conv1.addrb   = wh_addrb_conv1;
  assign wh_conv2.din     = wh_din_conv2;
  assign wh_conv2.ena     = wh_ena_conv2;
  assign wh_conv2.addra   = wh_addra_conv2;
  assign wh_conv2.addrb   = wh_addrb_conv2;
  assign feat_conv1.din   = feat_din_conv1;
  assign feat_conv1.ena   = feat_ena_conv1;
  assign feat_conv1.addra = feat_addra_conv1;
  assign feat_conv1.addrb = feat_addrb_conv1;
  assign feat_conv2.din   = feat_din_conv2;
  assign feat_conv2.ena   = feat_ena_conv2;
  assign feat_conv2.addra = feat_addra_conv2;
  assign feat_conv2.addrb = feat_addrb_conv2;

  gat_mem_regs u_regs (
    .clk              (clk),
    .reset            (reset),
    .cfg_we           (cfg_we),
    .cfg_addr         (gat_mem_pkg::cfg_addr_e'(cfg_addr)),
    .cfg_wdata        (cfg_wdata),
    .cfg_rdata        (cfg_rdata),
    .h_data_load_done (h_data_load_done),
    .wgt_load_done    (wgt_load_done),
    .gat_layer        (gat_layer)
  );

  memory_controller u_ctrl (
    .clk                (clk),
    .reset              (reset),
    .gat_layer          (gat_layer),
    .h_data_din         (h_data_din),
    .h_data_ena         (h_data_ena),
    .h_data_wea         (h_data_wea),
    .h_data_addra       (h_data_addra),
    .wgt_din            (wgt_din),
    .wgt_ena            (wgt_ena),
    .wgt_wea            (wgt_wea),
    .wgt_addra          (wgt_addra),
    .h_data_addrb_conv1 (h_data_addrb_conv1),
    .h_data_addrb_conv2 (h_data_addrb_conv2),
    .wgt_addrb_conv1    (wgt_addrb_conv1),
    .wgt_addrb_conv2    (wgt_addrb_conv2),
    .h_data_dout        (h_data_dout),
    .wgt_dout           (wgt_dout),
    .wh_conv1           (wh_conv1),
    .wh_conv2           (wh_conv2),
    .feat_conv1         (feat_conv1),
    .feat_conv2         (feat_conv2),
    .wh_addrc           (wh_addrc),
    .wh_dout            (wh_dout),
    .wh_doutc           (wh_doutc),
    .feat_dout          (feat_dout)
  );

endmodule

`default_nettype wire

//--- verif/tb_gat_mem_top.sv
// GAT memory subsystem testbench

`default_nettype none

`include "gat_mem_macros.svh"

module tb_gat_mem_top;

  localparam int MAX_CYCLES = 2000;

  logic                          clk = 1'b0;
  logic                          reset;
  logic [`GAT_H_DATA_WIDTH-1:0]  h_data_din;
  logic                          h_data_ena;
  logic                          h_data_wea;
  logic [`GAT_H_DATA_ADDR_W-1:0] h_data_addra;
  logic                          h_data_load_done;
  logic [`GAT_DATA_WIDTH-1:0]    wgt_din;
  logic                          wgt_ena;
  logic                          wgt_wea;
  logic [`GAT_WGT_ADDR_W-1:0]    wgt_addra;
  logic                          wgt_load_done;
  logic [`GAT_WH_ADDR_W-1:0]     wh_addrc;
  logic [`GAT_WH_WIDTH-1:0]      wh_doutc;
  logic                          cfg_we;
  logic [1:0]                    cfg_addr;
  logic [`GAT_CFG_WIDTH-1:0]     cfg_wdata;
  logic [`GAT_CFG_WIDTH-1:0]     cfg_rdata;
  logic [`GAT_H_DATA_ADDR_W-1:0] h_data_addrb_conv1;
  logic [`GAT_H_DATA_ADDR_W-1:0] h_data_addrb_conv2;
  logic [`GAT_WGT_ADDR_W-1:0]    wgt_addrb_conv1;
  logic [`GAT_WGT_ADDR_W-1:0]    wgt_addrb_conv2;
  logic [`GAT_H_DATA_WIDTH-1:0]  h_data_dout;
  logic [`GAT_DATA_WIDTH-1:0]    wgt_dout;
  logic [`GAT_WH_WIDTH-1:0]      wh_din_conv1;
  logic                          wh_ena_conv1;
  logic [`GAT_WH_ADDR_W-1:0]     wh_addra_conv1;
  logic [`GAT_WH_ADDR_W-1:0]     wh_addrb_conv1;
  logic [`GAT_WH_WIDTH-1:0]      wh_din_conv2;
  logic                          wh_ena_conv2;
  logic [`GAT_WH_ADDR_W-1:0]     wh_addra_conv2;
  logic [`GAT_WH_ADDR_W-1:0]     wh_addrb_conv2;
  logic [`GAT_WH_WIDTH-1:0]      wh_dout;
  logic [`GAT_FEAT_WIDTH-1:0]    feat_din_conv1;
  logic                          feat_ena_conv1;
  logic [`GAT_FEAT_ADDR_W-1:0]   feat_addra_conv1;
  logic [`GAT_FEAT_ADDR_W-1:0]   feat_addrb_conv1;
  logic [`GAT_FEAT_WIDTH-1:0]    feat_din_conv2;
  logic                          feat_ena_conv2;
  logic [`GAT_FEAT_ADDR_W-1:0]   feat_addra_conv2;
  logic [`GAT_FEAT_ADDR_W-1:0]   feat_addrb_conv2;
  logic [`GAT_FEAT_WIDTH-1:0]    feat_dout;

  integer      seed;
  logic [31:0] rnd;
  int          checks;
  int          errors;
  int          test_count;
  int          test_start_errors;
  bit          sim_done;

  // ==========================================================================
  // Reference model
  // ==========================================================================
  logic [`GAT_H_DATA_WIDTH-1:0] h_mem    [`GAT_H_DATA_DEPTH];
  logic [`GAT_DATA_WIDTH-1:0]   wgt_mem  [`GAT_WGT_DEPTH];
  logic [`GAT_WH_WIDTH-1:0]     wh_mem   [`GAT_WH_DEPTH];
  logic [`GAT_FEAT_WIDTH-1:0]   feat_mem [`GAT_FEAT_DEPTH];
  gat_mem_pkg::gat_layer_e      m_layer;
  logic                         m_h_done;
  logic                         m_wgt_done;
  logic [`GAT_H_DATA_WIDTH-1:0] e_h;
  logic [`GAT_DATA_WIDTH-1:0]   e_wgt;
  logic [`GAT_WH_WIDTH-1:0]     e_wh;
  logic [`GAT_WH_WIDTH-1:0]     e_whc;
  logic [`GAT_FEAT_WIDTH-1:0]   e_feat;

  gat_mem_top UUT (.*);

  always #4 clk = ~clk;

  // Model one rising edge from the inputs held since the last falling edge
  task automatic model_edge();
    logic                          sel1;
    logic                          clear;
    logic [`GAT_H_DATA_ADDR_W-1:0] ha;
    logic [`GAT_WGT_ADDR_W-1:0]    wa;
    logic [`GAT_WH_ADDR_W-1:0]     wha;
    logic [`GAT_FEAT_ADDR_W-1:0]   fa;
    sel1 = (m_layer == gat_mem_pkg::CONV1);
    ha   = sel1 ? h_data_addrb_conv1 : h_data_addrb_conv2;
    wa   = sel1 ? wgt_addrb_conv1 : wgt_addrb_conv2;
    wha  = sel1 ? wh_addrb_conv1 : wh_addrb_conv2;
    fa   = sel1 ? feat_addrb_conv1 : feat_addrb_conv2;
    // Reads see the contents from before this edge's writes
    e_h    = reset ? '0 : h_mem[ha];
    e_wgt  = reset ? '0 : wgt_mem[wa];
    e_wh   = reset ? '0 : wh_mem[wha];
    e_whc  = reset ? '0 : wh_mem[wh_addrc];
    e_feat = reset ? '0 : feat_mem[fa];
    if (h_data_ena && h_data_wea) begin
      h_mem[h_data_addra] = h_data_din;
    end
    if (wgt_ena && wgt_wea) begin
      wgt_mem[wgt_addra] = wgt_din;
    end
    if (sel1) begin
      if (wh_ena_conv1) begin
        wh_mem[wh_addra_conv1] = wh_din_conv1;
      end
      if (feat_ena_conv1) begin
        feat_mem[feat_addra_conv1] = feat_din_conv1;
      end
    end else begin
      if (wh_ena_conv2) begin
        wh_mem[wh_addra_conv2] = wh_din_conv2;
      end
      if (feat_ena_conv2) begin
        feat_mem[feat_addra_conv2] = feat_din_conv2;
      end
    end
    clear = cfg_we && (cfg_addr == gat_mem_pkg::CFG_CLEAR);
    if (reset) begin
      m_layer    = gat_mem_pkg::CONV1;
      m_h_done   = 1'b0;
      m_wgt_done = 1'b0;
    end else begin
      if (cfg_we && (cfg_addr == gat_mem_pkg::CFG_LAYER)) begin
        m_layer = gat_mem_pkg::gat_layer_e'(cfg_wdata[0]);
      end
      // Set wins over clear
      if (h_data_load_done) begin
        m_h_done = 1'b1;
      end else if (clear) begin
        m_h_done = 1'b0;
      end
      if (wgt_load_done) begin
        m_wgt_done = 1'b1;
      end else if (clear) begin
        m_wgt_done = 1'b0;
      end
    end
  endtask

  function automatic logic [`GAT_CFG_WIDTH-1:0] expected_cfg_rdata();
    logic [`GAT_CFG_WIDTH-1:0] value;
    value = '0;
    if (cfg_addr == gat_mem_pkg::CFG_LAYER) begin
      value[0] = m_layer;
    end else if (cfg_addr == gat_mem_pkg::CFG_STATUS) begin
      value[0] = m_h_done;
      value[1] = m_wgt_done;
      value[2] = m_h_done && m_wgt_done;
    end
    return value;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Error at time %0t: %s expected 'h%0h, got 'h%0h",
               $time, name, expected, actual);
    end
  endtask

  task automatic compare_outputs();
    check_value("h_data_dout", 32'(e_h), 32'(h_data_dout));
    check_value("wgt_dout", 32'(e_wgt), 32'(wgt_dout));
    check_value("wh_dout", 32'(e_wh), 32'(wh_dout));
    check_value("wh_doutc", 32'(e_whc), 32'(wh_doutc));
    check_value("feat_dout", 32'(e_feat), 32'(feat_dout));
    check_value("cfg_rdata", 32'(expected_cfg_rdata()), 32'(cfg_rdata));
  endtask

  // One clock cycle with the compare at the falling edge
  task automatic tick();
    @(posedge clk);
    model_edge();
    @(negedge clk);
    compare_outputs();
  endtask

  task automatic begin_test();
    test_count++;
    test_start_errors = errors;
  endtask

  task automatic report_test(input string name);
    $display("Test %0d (%s): %0d error(s)", test_count, name, errors - test_start_errors);
  endtask

  task automatic write_cfg(input logic [1:0] addr, input logic [`GAT_CFG_WIDTH-1:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    tick();
    cfg_we = 1'b0;
  endtask

  // Random addresses for both layers with result writes only when asked
  task automatic drive_layer_traffic(input bit with_writes);
    logic [`GAT_WH_ADDR_W-1:0] wh_offset;
    rnd = $random(seed);
    h_data_addrb_conv1 = rnd[0 +: `GAT_H_DATA_ADDR_W];
    wgt_addrb_conv1    = rnd[8 +: `GAT_WGT_ADDR_W];
    wh_addrb_conv1     = rnd[16 +: `GAT_WH_ADDR_W];
    feat_addrb_conv1   = rnd[24 +: `GAT_FEAT_ADDR_W];
    rnd = $random(seed);
    h_data_addrb_conv2 = rnd[0 +: `GAT_H_DATA_ADDR_W];
    wgt_addrb_conv2    = rnd[8 +: `GAT_WGT_ADDR_W];
    wh_addrb_conv2     = rnd[16 +: `GAT_WH_ADDR_W];
    feat_addrb_conv2   = rnd[24 +: `GAT_FEAT_ADDR_W];
    rnd = $random(seed);
    wh_din_conv1 = rnd[`GAT_WH_WIDTH-1:0];
    rnd = $random(seed);
    wh_din_conv2 = rnd[`GAT_WH_WIDTH-1:0];
    rnd = $random(seed);
    feat_din_conv1 = rnd[0 +: `GAT_FEAT_WIDTH];
    feat_din_conv2 = rnd[16 +: `GAT_FEAT_WIDTH];
    rnd = $random(seed);
    wh_ena_conv1     = with_writes && rnd[0];
    wh_ena_conv2     = with_writes && rnd[1];
    feat_ena_conv1   = with_writes && rnd[2];
    feat_ena_conv2   = with_writes && rnd[3];
    wh_addra_conv1   = rnd[8 +: `GAT_WH_ADDR_W];
    wh_addra_conv2   = rnd[13 +: `GAT_WH_ADDR_W];
    feat_addra_conv1 = rnd[18 +: `GAT_FEAT_ADDR_W];
    feat_addra_conv2 = rnd[23 +: `GAT_FEAT_ADDR_W];
    // Host port reads a different row than the active layer
    rnd = $random(seed);
    wh_offset    = rnd[`GAT_WH_ADDR_W-1:0];
    wh_offset[0] = 1'b1;
    wh_addrc = (m_layer == gat_mem_pkg::CONV1) ? wh_addrb_conv1 + wh_offset
                                               : wh_addrb_conv2 + wh_offset;
  endtask

  // Random host loads that sometimes hit the address being read
  task automatic drive_host_writes();
    rnd = $random(seed);
    h_data_ena   = rnd[0];
    h_data_wea   = rnd[1];
    wgt_ena      = rnd[2];
    wgt_wea      = rnd[3];
    h_data_addra = rnd[4] ? h_data_addrb_conv1 : rnd[8 +: `GAT_H_DATA_ADDR_W];
    wgt_addra    = rnd[5] ? wgt_addrb_conv1 : rnd[16 +: `GAT_WGT_ADDR_W];
    rnd = $random(seed);
    h_data_din = rnd[0 +: `GAT_H_DATA_WIDTH];
    wgt_din    = rnd[16 +: `GAT_DATA_WIDTH];
  endtask

  task automatic init_inputs();
    reset            = 1'b1;
    h_data_din       = '0;
    h_data_ena       = 1'b0;
    h_data_wea       = 1'b0;
    h_data_addra     = '0;
    h_data_load_done = 1'b0;
    wgt_din          = '0;
    wgt_ena          = 1'b0;
    wgt_wea          = 1'b0;
    wgt_addra        = '0;
    wgt_load_done    = 1'b0;
    cfg_we           = 1'b0;
    cfg_addr         = gat_mem_pkg::CFG_LAYER;
    cfg_wdata        = '0;
    m_layer          = gat_mem_pkg::CONV1;
    m_h_done         = 1'b0;
    m_wgt_done       = 1'b0;
    drive_layer_traffic(1'b0);
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin : main
    seed       = 32'h3ba5_c1ca;
    checks     = 0;
    errors     = 0;
    test_count = 0;
    sim_done   = 1'b0;
    init_inputs();

    begin_test();
    for (int i = 0; i < 10; i++) begin
      cfg_addr = (i < 5) ? gat_mem_pkg::CFG_LAYER : gat_mem_pkg::CFG_STATUS;
      tick();
    end
    check_value("cfg_rdata", 32'h0, 32'(cfg_rdata));
    check_value("h_data_dout", 32'h0, 32'(h_data_dout));
    reset = 1'b0;
    report_test("reset values");

    begin_test();
    for (int a = 0; a < `GAT_H_DATA_DEPTH; a++) begin
      drive_host_writes();
      h_data_ena   = 1'b1;
      h_data_wea   = 1'b1;
      wgt_ena      = 1'b1;
      wgt_wea      = 1'b1;
      h_data_addra = a[`GAT_H_DATA_ADDR_W-1:0];
      wgt_addra    = a[`GAT_WGT_ADDR_W-1:0];
      tick();
    end
    for (int i = 0; i < 40; i++) begin
      drive_layer_traffic(1'b0);
      drive_host_writes();
      tick();
    end
    h_data_ena = 1'b0;
    wgt_ena    = 1'b0;
    report_test("host load and conv1 reads");

    begin_test();
    write_cfg(gat_mem_pkg::CFG_LAYER, 8'h01);
    check_value("cfg_rdata", 32'h1, 32'(cfg_rdata));
    for (int i = 0; i < 30; i++) begin
      drive_layer_traffic(1'b0);
      tick();
    end
    write_cfg(gat_mem_pkg::CFG_LAYER, 8'h00);
    check_value("cfg_rdata", 32'h0, 32'(cfg_rdata));
    for (int i = 0; i < 20; i++) begin
      drive_layer_traffic(1'b0);
      tick();
    end
    report_test("layer switching");

    begin_test();
    for (int a = 0; a < `GAT_WH_DEPTH; a++) begin
      drive_layer_traffic(1'b1);
      wh_ena_conv1     = 1'b1;
      feat_ena_conv1   = 1'b1;
      wh_addra_conv1   = a[`GAT_WH_ADDR_W-1:0];
      feat_addra_conv1 = a[`GAT_FEAT_ADDR_W-1:0];
      tick();
    end
    for (int i = 0; i < 60; i++) begin
      drive_layer_traffic(1'b1);
      if (i == 30) begin
        write_cfg(gat_mem_pkg::CFG_LAYER, 8'h01);
      end else begin
        tick();
      end
    end
    drive_layer_traffic(1'b0);
    write_cfg(gat_mem_pkg::CFG_LAYER, 8'h00);
    report_test("result writes and host reads");

    begin_test();
    cfg_addr         = gat_mem_pkg::CFG_STATUS;
    h_data_load_done = 1'b1;
    tick();
    h_data_load_done = 1'b0;
    tick();
    check_value("cfg_rdata", 32'h1, 32'(cfg_rdata));
    wgt_load_done = 1'b1;
    tick();
    wgt_load_done = 1'b0;
    tick();
    check_value("cfg_rdata", 32'h7, 32'(cfg_rdata));
    write_cfg(gat_mem_pkg::CFG_CLEAR, 8'h00);
    cfg_addr = gat_mem_pkg::CFG_STATUS;
    tick();
    check_value("cfg_rdata", 32'h0, 32'(cfg_rdata));
    // Pulse and clear on the same edge
    wgt_load_done = 1'b1;
    tick();
    wgt_load_done    = 1'b0;
    h_data_load_done = 1'b1;
    write_cfg(gat_mem_pkg::CFG_CLEAR, 8'h00);
    h_data_load_done = 1'b0;
    cfg_addr         = gat_mem_pkg::CFG_STATUS;
    tick();
    check_value("cfg_rdata", 32'h1, 32'(cfg_rdata));
    for (int i = 0; i < 20; i++) begin
      rnd = $random(seed);
      h_data_load_done = rnd[0] && rnd[1];
      wgt_load_done    = rnd[2] && rnd[3];
      cfg_we           = rnd[4];
      cfg_addr         = rnd[5] ? gat_mem_pkg::CFG_CLEAR : gat_mem_pkg::CFG_STATUS;
      cfg_wdata        = rnd[15:8];
      tick();
    end
    report_test("load-done status");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    sim_done = 1'b1;
    $finish;
  end

  initial begin : watchdog
    int waited;
    waited = 0;
    while (!sim_done && waited < MAX_CYCLES) begin
      #8;
      waited++;
    end
    if (!sim_done) begin
      $display("Timeout: the test sequence did not finish within %0d clock periods",
               MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/gat_mem_pkg.sv
design/gat_bram_if.sv
design/bram.sv
design/dual_read_bram.sv
design/gat_mem_regs.sv
design/memory_controller.sv
design/gat_mem_top.sv
verif/tb_gat_mem_top.sv

//--- Makefile
# Verilator build, run and lint for the GAT memory subsystem

VERILATOR  ?= verilator
FILELIST   ?= build.f
TB_TOP     ?= tb_gat_mem_top
DUT_TOP    ?= gat_mem_top
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR)
